// File: design/conv_pkg.sv
package conv_pkg;

    // pipeline phases of one convolution job
    typedef enum logic [1:0] {
        IDLE,
        MULT,
        REDUCE,
        FINISH
    } conv_state_e;

    // word addresses on the Wishbone port, taps follow PIX0 and WGT0
    typedef enum logic [5:0] {
        PIX0   = 6'h00,
        WGT0   = 6'h10,
        CTRL   = 6'h20,
        STATUS = 6'h21,
        RESULT = 6'h22
    } conv_addr_e;

    typedef struct packed {
        logic start;
        logic relu_en;
    } conv_ctrl_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic sat;
    } conv_status_t;

    typedef struct packed {
        logic       mul_en;
        logic [3:0] lvl_en;
        logic       out_en;
    } conv_stage_t;

endpackage

// File: design/conv_wb_regs.sv
`timescale 1ns/1ps

module conv_wb_regs #(
    parameter int DATA_W = 16,
    parameter int TAPS   = 9
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [5:0]                 i_wb_adr,
    input  logic [31:0]                i_wb_dat,
    output logic [31:0]                o_wb_dat,
    output logic                       o_wb_ack,
    input  conv_pkg::conv_status_t     i_status,
    input  logic [DATA_W-1:0]          i_result,
    input  logic                       i_sat,
    input  logic                       i_out_en,
    output logic [TAPS*DATA_W-1:0]     o_window,
    output logic [TAPS*DATA_W-1:0]     o_kernel,
    output conv_pkg::conv_ctrl_t       o_ctrl
);

    conv_pkg::conv_addr_e adr;
    logic [DATA_W-1:0]    pix_q [TAPS];
    logic [DATA_W-1:0]    wgt_q [TAPS];
    logic [DATA_W-1:0]    result_q;
    logic [31:0]          rd_data;
    logic [31:0]          dat_q;
    logic                 ack_q;
    logic                 req;
    logic                 wr_en;
    logic                 start_q;
    logic                 relu_q;
    logic                 sat_q;
    logic                 out_q;

    assign adr   = conv_pkg::conv_addr_e'(i_wb_adr);
    // a new access is seen once per strobe, the cycle after ack drops it is not
    assign req   = i_wb_cyc && i_wb_stb && !ack_q;
    assign wr_en = req && i_wb_we;

    always_ff @(posedge clk) begin
        for (int k = 0; k < TAPS; k++) begin
            if (wr_en && i_wb_adr == 6'(conv_pkg::PIX0 + k)) begin
                pix_q[k] <= i_wb_dat[DATA_W-1:0];
            end
            if (wr_en && i_wb_adr == 6'(conv_pkg::WGT0 + k)) begin
                wgt_q[k] <= i_wb_dat[DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            relu_q   <= 1'b0;
            out_q    <= 1'b0;
            result_q <= '0;
            sat_q    <= 1'b0;
        end else begin
            ack_q   <= req;
            start_q <= wr_en && adr == conv_pkg::CTRL && i_wb_dat[0];
            if (wr_en && adr == conv_pkg::CTRL) begin
                relu_q <= i_wb_dat[1];
            end
            // the tree result register updates on out_en, so take it one cycle later
            out_q <= i_out_en;
            if (out_q) begin
                result_q <= i_result;
                sat_q    <= i_sat;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        for (int k = 0; k < TAPS; k++) begin
            if (i_wb_adr == 6'(conv_pkg::PIX0 + k)) begin
                rd_data[DATA_W-1:0] = pix_q[k];
            end
            if (i_wb_adr == 6'(conv_pkg::WGT0 + k)) begin
                rd_data[DATA_W-1:0] = wgt_q[k];
            end
        end
        case (adr)
            conv_pkg::CTRL:   rd_data[1] = relu_q;
            conv_pkg::STATUS: rd_data[2:0] = {sat_q, i_status.done, i_status.busy};
            conv_pkg::RESULT: rd_data[DATA_W-1:0] = result_q;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    for (genvar t = 0; t < TAPS; t++) begin : g_pack
        assign o_window[t*DATA_W +: DATA_W] = pix_q[t];
        assign o_kernel[t*DATA_W +: DATA_W] = wgt_q[t];
    end

    assign o_wb_dat       = dat_q;
    assign o_wb_ack       = ack_q;
    assign o_ctrl.start   = start_q;
    assign o_ctrl.relu_en = relu_q;

endmodule

// File: design/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_start,
    output conv_pkg::conv_stage_t o_stage,
    output logic                  o_status_busy,
    output logic                  o_status_done
);

    conv_pkg::conv_state_e state;
    logic [1:0]            lvl_cnt;
    logic                  busy_q;
    logic                  done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= conv_pkg::IDLE;
            lvl_cnt <= 2'd0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            case (state)
                conv_pkg::IDLE: begin
                    if (i_start) begin
                        state  <= conv_pkg::MULT;
                        busy_q <= 1'b1;
                        done_q <= 1'b0;
                    end
                end
                conv_pkg::MULT: begin
                    state   <= conv_pkg::REDUCE;
                    lvl_cnt <= 2'd0;
                end
                conv_pkg::REDUCE: begin
                    lvl_cnt <= lvl_cnt + 2'd1;
                    // last tree level done, the job is complete from the host view
                    if (lvl_cnt == 2'd3) begin
                        state  <= conv_pkg::FINISH;
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= conv_pkg::IDLE;
                end
            endcase
        end
    end

    // stage enables follow the state directly, one stage per cycle
    always_comb begin
        o_stage = '0;
        case (state)
            conv_pkg::MULT:   o_stage.mul_en = 1'b1;
            conv_pkg::REDUCE: o_stage.lvl_en = 4'b0001 << lvl_cnt;
            conv_pkg::FINISH: o_stage.out_en = 1'b1;
            default: begin
            end
        endcase
    end

    assign o_status_busy = busy_q;
    assign o_status_done = done_q;

endmodule

// File: design/conv_mult_array.sv
`timescale 1ns/1ps

module conv_mult_array #(
    parameter int DATA_W = 16,
    parameter int TAPS   = 9
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_mul_en,
    input  logic [TAPS*DATA_W-1:0]     i_window,
    input  logic [TAPS*DATA_W-1:0]     i_kernel,
    output logic [TAPS*2*DATA_W-1:0]   o_products
);

    localparam int PROD_W = 2 * DATA_W;

    for (genvar t = 0; t < TAPS; t++) begin : g_tap
        logic signed [DATA_W-1:0] pix;
        logic signed [DATA_W-1:0] wgt;
        logic signed [PROD_W-1:0] prod_q;

        assign pix = i_window[t*DATA_W +: DATA_W];
        assign wgt = i_kernel[t*DATA_W +: DATA_W];

        // Q8.8 times Q8.8 gives Q16.16, kept at full width
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                prod_q <= '0;
            end else if (i_mul_en) begin
                prod_q <= pix * wgt;
            end
        end

        assign o_products[t*PROD_W +: PROD_W] = prod_q;
    end

endmodule

// File: design/conv_adder_tree.sv
`timescale 1ns/1ps

module conv_adder_tree #(
    parameter int DATA_W = 16,
    parameter int FRAC_W = 8,
    parameter int TAPS   = 9,
    parameter int ACC_W  = 36
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  conv_pkg::conv_stage_t      i_stage,
    input  logic                       i_relu_en,
    input  logic [TAPS*2*DATA_W-1:0]   i_products,
    output logic [DATA_W-1:0]          o_result,
    output logic                       o_sat
);

    localparam int PROD_W = 2 * DATA_W;
    localparam logic signed [ACC_W-1:0] SAT_MAX =
        {{(ACC_W-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

    logic signed [ACC_W-1:0]  ext [TAPS];
    logic signed [ACC_W-1:0]  lvl1_q [4];
    logic signed [ACC_W-1:0]  lvl2_q [2];
    logic signed [ACC_W-1:0]  lvl3_q;
    logic signed [ACC_W-1:0]  lvl4_q;
    logic signed [ACC_W-1:0]  shifted;
    logic [DATA_W-1:0]        clip_val;
    logic [DATA_W-1:0]        final_val;
    logic                     clip;
    logic [DATA_W-1:0]        result_q;
    logic                     sat_q;

    for (genvar t = 0; t < TAPS; t++) begin : g_ext
        assign ext[t] = {{(ACC_W-PROD_W){i_products[t*PROD_W+PROD_W-1]}},
                         i_products[t*PROD_W +: PROD_W]};
    end

    // taps 0 to 7 reduce in pairs, the last tap joins at level 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvl1_q <= '{default: '0};
            lvl2_q <= '{default: '0};
            lvl3_q <= '0;
            lvl4_q <= '0;
        end else begin
            if (i_stage.lvl_en[0]) begin
                for (int k = 0; k < 4; k++) begin
                    lvl1_q[k] <= ext[2*k] + ext[2*k+1];
                end
            end
            if (i_stage.lvl_en[1]) begin
                lvl2_q[0] <= lvl1_q[0] + lvl1_q[1];
                lvl2_q[1] <= lvl1_q[2] + lvl1_q[3];
            end
            if (i_stage.lvl_en[2]) begin
                lvl3_q <= lvl2_q[0] + lvl2_q[1];
            end
            if (i_stage.lvl_en[3]) begin
                lvl4_q <= lvl3_q + ext[TAPS-1];
            end
        end
    end

    // back to Q8.8, rounding toward minus infinity
    always_comb begin
        shifted = lvl4_q >>> FRAC_W;
        clip    = 1'b0;
        if (shifted > SAT_MAX) begin
            clip     = 1'b1;
            clip_val = {1'b0, {(DATA_W-1){1'b1}}};
        end else if (shifted < SAT_MIN) begin
            clip     = 1'b1;
            clip_val = {1'b1, {(DATA_W-1){1'b0}}};
        end else begin
            clip_val = shifted[DATA_W-1:0];
        end
        final_val = (i_relu_en && clip_val[DATA_W-1]) ? '0 : clip_val;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
            sat_q    <= 1'b0;
        end else if (i_stage.out_en) begin
            result_q <= final_val;
            sat_q    <= clip;
        end
    end

    assign o_result = result_q;
    assign o_sat    = sat_q;

endmodule

// File: design/conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [5:0]  i_wb_adr,
    input  logic [31:0] i_wb_dat,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;
    localparam int TAPS   = 9;
    localparam int ACC_W  = 36;

    logic [TAPS*DATA_W-1:0]   window;
    logic [TAPS*DATA_W-1:0]   kernel;
    logic [TAPS*2*DATA_W-1:0] products;
    logic [DATA_W-1:0]        result;
    logic                     sat;
    logic                     busy;
    logic                     done;
    conv_pkg::conv_ctrl_t     ctrl;
    conv_pkg::conv_stage_t    stage;
    conv_pkg::conv_status_t   status;

    assign status.busy = busy;
    assign status.done = done;
    assign status.sat  = sat;

    conv_wb_regs #(.DATA_W(DATA_W), .TAPS(TAPS)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_status (status),
        .i_result (result),
        .i_sat    (sat),
        .i_out_en (stage.out_en),
        .o_window (window),
        .o_kernel (kernel),
        .o_ctrl   (ctrl)
    );

    conv_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (ctrl.start),
        .o_stage       (stage),
        .o_status_busy (busy),
        .o_status_done (done)
    );

    conv_mult_array #(.DATA_W(DATA_W), .TAPS(TAPS)) u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_mul_en   (stage.mul_en),
        .i_window   (window),
        .i_kernel   (kernel),
        .o_products (products)
    );

    conv_adder_tree #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W),
        .TAPS   (TAPS),
        .ACC_W  (ACC_W)
    ) u_tree (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stage    (stage),
        .i_relu_en  (ctrl.relu_en),
        .i_products (products),
        .o_result   (result),
        .o_sat      (sat)
    );

endmodule

// File: dv/conv_ref.svh
typedef struct packed {
    logic [TAPS*DATA_W-1:0] pix;
    logic [TAPS*DATA_W-1:0] wgt;
    logic                   relu;
} job_t;

typedef struct packed {
    logic              sat;
    logic [DATA_W-1:0] value;
} expect_t;

int check_count = 0;
int err_count   = 0;

// exact Q16.16 dot product, back to Q8.8 by an arithmetic shift, then clip, then ReLU
function automatic expect_t conv_ref(input job_t j);
    longint  sum;
    longint  shifted;
    longint  hi;
    longint  lo;
    expect_t r;
    sum = 0;
    hi  = (longint'(1) << (DATA_W - 1)) - 1;
    lo  = -hi - 1;
    for (int k = 0; k < TAPS; k++) begin
        sum += longint'($signed(j.pix[k*DATA_W +: DATA_W])) *
               longint'($signed(j.wgt[k*DATA_W +: DATA_W]));
    end
    shifted = sum >>> FRAC_W;
    r.sat   = 1'b0;
    if (shifted > hi) begin
        r.sat   = 1'b1;
        r.value = {1'b0, {(DATA_W-1){1'b1}}};
    end else if (shifted < lo) begin
        r.sat   = 1'b1;
        r.value = {1'b1, {(DATA_W-1){1'b0}}};
    end else begin
        r.value = shifted[DATA_W-1:0];
    end
    if (j.relu && r.value[DATA_W-1]) begin
        r.value = '0;
    end
    return r;
endfunction

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        err_count++;
        $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
endtask

// File: dv/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

    localparam int TAPS           = 9;
    localparam int DATA_W         = 16;
    localparam int FRAC_W         = 8;
    localparam int NUM_JOBS       = 50;
    localparam int JOB_CYCLES     = 80;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * JOB_CYCLES + 2000;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat;
    logic [31:0] rd_dat;
    logic        ack;

    `include "conv_ref.svh"

    integer      seed;
    int          cycle_count = 0;
    int          errs_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       cur_test;
    logic [16:0] exp_q [$];
    logic [16:0] act_q [$];

    conv_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat),
        .o_wb_dat (rd_dat),
        .o_wb_ack (ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // job results are scored against the model here, in the order the jobs ran
    always @(posedge clk) begin : compare_results
        logic [16:0] e;
        logic [16:0] a;
        while (exp_q.size() > 0 && act_q.size() > 0) begin
            e = exp_q.pop_front();
            a = act_q.pop_front();
            check({cur_test, " result"}, e[15:0], a[15:0]);
            check({cur_test, " sat"}, e[16], a[16]);
        end
    end

    task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
        int waits;
        waits = 1;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = adr;
        wb_dat = dat;
        @(posedge clk);
        #1;
        while (!ack) begin
            waits++;
            @(posedge clk);
            #1;
        end
        check("wb write ack latency", 32'd1, waits);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
        int waits;
        waits = 1;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(posedge clk);
        #1;
        while (!ack) begin
            waits++;
            @(posedge clk);
            #1;
        end
        check("wb read ack latency", 32'd1, waits);
        dat    = rd_dat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    function automatic job_t uniform_job(input logic [15:0] p, input logic [15:0] w,
                                         input logic relu);
        job_t j;
        for (int k = 0; k < TAPS; k++) begin
            j.pix[k*DATA_W +: DATA_W] = p;
            j.wgt[k*DATA_W +: DATA_W] = w;
        end
        j.relu = relu;
        return j;
    endfunction

    // loads the operands, starts (twice if asked), polls done, then reads RESULT and STATUS
    task automatic run_job(input job_t j, input bit double_start, output logic [15:0] res,
                           output logic [2:0] st);
        logic [31:0] rd;
        for (int k = 0; k < TAPS; k++) begin
            wb_write(conv_pkg::PIX0 + k[5:0], {16'h0, j.pix[k*DATA_W +: DATA_W]});
            wb_write(conv_pkg::WGT0 + k[5:0], {16'h0, j.wgt[k*DATA_W +: DATA_W]});
        end
        exp_q.push_back(conv_ref(j));
        wb_write(conv_pkg::CTRL, {30'h0, j.relu, 1'b1});
        if (double_start) begin
            wb_write(conv_pkg::CTRL, {30'h0, j.relu, 1'b1});
        end
        wb_read(conv_pkg::STATUS, rd);
        while (!rd[1]) begin
            wb_read(conv_pkg::STATUS, rd);
        end
        wb_read(conv_pkg::RESULT, rd);
        res = rd[15:0];
        wb_read(conv_pkg::STATUS, rd);
        st = rd[2:0];
        act_q.push_back({st[2], res});
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("test %-12s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-12s %0d errors", cur_test, err_count - errs_at_start);
        end
    endtask

    initial begin : main
        job_t        j;
        logic [15:0] res;
        logic [2:0]  st;
        logic [31:0] rd;
        logic [15:0] v;
        seed   = 32'h320bfe3d;
        rst_n  = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("readback");
        wb_read(conv_pkg::STATUS, rd);
        check("status after reset", 32'h0, rd);
        for (int k = 0; k < TAPS; k++) begin
            wb_write(conv_pkg::PIX0 + k[5:0], 32'h1357 + k * 32'h0101);
            wb_write(conv_pkg::WGT0 + k[5:0], 32'hF00D - k * 32'h0203);
        end
        for (int k = 0; k < TAPS; k++) begin
            wb_read(conv_pkg::PIX0 + k[5:0], rd);
            check("pixel readback", 32'h1357 + k * 32'h0101, rd);
            wb_read(conv_pkg::WGT0 + k[5:0], rd);
            check("weight readback", 32'hF00D - k * 32'h0203, rd);
        end
        wb_write(conv_pkg::CTRL, 32'h2);
        wb_read(conv_pkg::CTRL, rd);
        check("relu_en set", 32'h2, rd);
        wb_write(conv_pkg::CTRL, 32'h0);
        wb_read(conv_pkg::CTRL, rd);
        check("relu_en clear", 32'h0, rd);
        end_test();

        begin_test("directed");
        j = uniform_job(16'h0, 16'h0, 1'b0);
        for (int k = 0; k < TAPS; k++) begin
            j.pix[k*DATA_W +: DATA_W] = 16'h0100 + k[15:0] * 16'h0033;
        end
        j.wgt[4*DATA_W +: DATA_W] = 16'h0100;
        run_job(j, 1'b0, res, st);
        check("identity centre", j.pix[4*DATA_W +: DATA_W], res);
        check("busy after job", 1'b0, st[0]);
        check("done after job", 1'b1, st[1]);
        run_job(uniform_job(16'h0100, 16'h0100, 1'b0), 1'b0, res, st);
        check("all ones", 16'h0900, res);
        for (int k = 0; k < TAPS; k++) begin
            j.pix[k*DATA_W +: DATA_W] = (k % 2) ? 16'hFE80 : 16'h0240;
            j.wgt[k*DATA_W +: DATA_W] = (k % 3 == 0) ? 16'hFFA0 : 16'h0050 + k[15:0];
        end
        run_job(j, 1'b0, res, st);
        check("mixed sat", 1'b0, st[2]);
        end_test();

        begin_test("relu");
        run_job(uniform_job(16'h0100, 16'hFF80, 1'b1), 1'b0, res, st);
        check("relu on", 16'h0000, res);
        run_job(uniform_job(16'h0100, 16'hFF80, 1'b0), 1'b0, res, st);
        check("relu off", 16'hFB80, res);
        end_test();

        begin_test("saturate");
        run_job(uniform_job(16'h7FFF, 16'h7FFF, 1'b0), 1'b0, res, st);
        check("clip high", 16'h7FFF, res);
        check("sat high", 1'b1, st[2]);
        run_job(uniform_job(16'h7FFF, 16'h8000, 1'b0), 1'b0, res, st);
        check("clip low", 16'h8000, res);
        check("sat low", 1'b1, st[2]);
        run_job(uniform_job(16'h0100, 16'h0100, 1'b0), 1'b0, res, st);
        check("sat cleared", 1'b0, st[2]);
        end_test();

        begin_test("busy_start");
        run_job(uniform_job(16'h0180, 16'h0200, 1'b0), 1'b1, res, st);
        check("first job result", 16'h1B00, res);
        check("first job busy", 1'b0, st[0]);
        check("first job done", 1'b1, st[1]);
        // a second job would raise busy and clear done somewhere in this window
        for (int n = 0; n < 8; n++) begin
            wb_read(conv_pkg::STATUS, rd);
            check("no second job busy", 1'b0, rd[0]);
            check("no second job done", 1'b1, rd[1]);
        end
        end_test();

        begin_test("random");
        for (int n = 0; n < 40; n++) begin
            for (int k = 0; k < TAPS; k++) begin
                j.pix[k*DATA_W +: DATA_W] = $random(seed);
                v = $random(seed);
                // every other job uses small weights so that most results stay in range
                if (n % 2) begin
                    v = {{6{v[15]}}, v[15:6]};
                end
                j.wgt[k*DATA_W +: DATA_W] = v;
            end
            j.relu = $random(seed);
            run_job(j, 1'b0, res, st);
        end
        end_test();

        if (exp_q.size() != act_q.size()) begin
            err_count++;
            $display("error: %0d job results were never compared", exp_q.size());
        end
        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+dv
design/conv_pkg.sv
design/conv_wb_regs.sv
design/conv_ctrl.sv
design/conv_mult_array.sv
design/conv_adder_tree.sv
design/conv_top.sv
dv/conv_tb.sv
